//--- verilog/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// machine word width in bits
`define CPU_XLEN 32

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// instruction memory depth, in words
// must be a power of two, the index wraps at the top
`define CPU_IMEM_WORDS 256

`endif

//--- verilog/rv_isa.sv
`include "cpu_config.svh"

// RV32I encoding: major opcodes, decode classes, instruction views
package rv_isa;

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_ALU_IMM, CLS_LOAD, CLS_STORE,
        CLS_BRANCH, CLS_JUMP, CLS_UPPER, CLS_ILLEGAL
    } inst_class_t;

    // register layout, I-type immediate sits in funct7:rs2
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } rtype_t;

    // immediate layout, slices shared by the S, B, U and J formats
    typedef struct packed {
        logic       sign;      // bit 31 in every format
        logic [5:0] imm_30_25;
        logic [3:0] imm_24_21;
        logic       imm_20;    // J imm[11]
        logic [7:0] imm_19_12; // U/J only
        logic [3:0] imm_11_8;  // S imm[4:1], B imm[4:1]
        logic       imm_7;     // S imm[0], B imm[11]
        opcode_t    opcode;
    } imm_view_t;

    typedef union packed {
        rtype_t    r;
        imm_view_t m;
    } instr_u;

    function automatic logic [`CPU_XLEN-1:0] imm_i(instr_u in);
        return {{(`CPU_XLEN-12){in.r.funct7[6]}}, in.r.funct7, in.r.rs2};
    endfunction

    function automatic logic [`CPU_XLEN-1:0] imm_s(instr_u in);
        return {{(`CPU_XLEN-11){in.m.sign}}, in.m.imm_30_25, in.m.imm_11_8, in.m.imm_7};
    endfunction

    function automatic logic [`CPU_XLEN-1:0] imm_b(instr_u in);
        return {{(`CPU_XLEN-12){in.m.sign}}, in.m.imm_7, in.m.imm_30_25,
                in.m.imm_11_8, 1'b0};
    endfunction

    function automatic logic [`CPU_XLEN-1:0] imm_u(instr_u in);
        return {{(`CPU_XLEN-31){in.m.sign}}, in.m.imm_30_25, in.m.imm_24_21,
                in.m.imm_20, in.m.imm_19_12, 12'h000};
    endfunction

    function automatic logic [`CPU_XLEN-1:0] imm_j(instr_u in);
        return {{(`CPU_XLEN-20){in.m.sign}}, in.m.imm_19_12, in.m.imm_20,
                in.m.imm_30_25, in.m.imm_24_21, 1'b0};
    endfunction

endpackage

//--- verilog/common.sv
`include "cpu_config.svh"

// machine words and the records passed between pipeline stages
package common;

    typedef logic [`CPU_XLEN-1:0] word_t;   // one machine word
    typedef logic [4:0]           reg_addr_t; // x0..x31

    // bubble marker, pc never reaches all ones in a real program
    localparam word_t NOP_PC = '1;
    localparam word_t NOP_IR = 32'h0000_0013; // addi x0, x0, 0

    // fetch -> decode
    typedef struct packed {
        word_t pc;   // address of ir
        word_t ir;   // raw instruction
    } if_out_t;

    // decode -> execute
    typedef struct packed {
        word_t               pc;
        rv_isa::inst_class_t iclass; // coarse class for the back end
        reg_addr_t           rd;     // raw fields, unused ones passed as-is
        reg_addr_t           rs1;
        reg_addr_t           rs2;
        word_t               imm;    // sign-extended, format picked by opcode
        logic                bubble; // slot carries no instruction
    } id_out_t;

endpackage

//--- verilog/cpu_if.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

// instruction fetch
// pc_q always names the word that imem_data_i carries this cycle
module cpu_if (
    input  wire logic          clk_i,
    input  wire logic          reset_i,
    input  wire logic          halt_i,

    output common::word_t      imem_addr_o,       // address for next cycle's data
    input  wire common::word_t imem_data_i,       // word at pc_q

    input  wire common::word_t jmp_addr_async_i,  // same-cycle redirect from decode
    input  wire logic          jmp_valid_async_i,
    input  wire logic          ready_async_i,     // downstream takes a word at the edge

    output common::if_out_t    if_o
);

    import common::*;

    word_t pc_q; // pc of the word arriving from memory
    word_t pc_d;

    // next pc, priority order matters
    always_comb begin
        if (reset_i) begin
            pc_d = `CPU_RESET_PC;
        end else if (halt_i) begin
            pc_d = pc_q;               // freeze
        end else if (jmp_valid_async_i) begin
            pc_d = jmp_addr_async_i;   // redirect wins over stall
        end else if (!ready_async_i) begin
            pc_d = pc_q;               // back-pressure
        end else begin
            pc_d = pc_q + word_t'(4);
        end
    end

    // memory read is registered, so ask for the next pc now
    assign imem_addr_o = pc_d;

    always_ff @(posedge clk_i) begin
        pc_q <= pc_d; // reset handled through pc_d
    end

    // fetch output register
    always_ff @(posedge clk_i) begin
        if (jmp_valid_async_i || reset_i) begin
            // kill the wrong-path word behind the jump
            if_o <= '{pc: NOP_PC, ir: NOP_IR};
        end else if (ready_async_i && !halt_i) begin
            if_o <= '{pc: pc_q, ir: imem_data_i};
        end
        // else hold for decode, a halted jal waits here
    end

endmodule

//--- verilog/imem.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

// instruction memory, one read port and one load port
module imem (
    input  wire logic          clk_i,
    input  wire common::word_t addr_i,   // byte address, read
    input  wire logic          we_i,     // load strobe
    input  wire common::word_t waddr_i,  // byte address, write
    input  wire common::word_t wdata_i,
    output common::word_t      rdata_o   // one cycle after addr_i
);

    import common::*;

    localparam int unsigned BYTE_BITS = $clog2(`CPU_XLEN / 8); // byte offset in a word
    localparam int unsigned IDX_BITS  = $clog2(`CPU_IMEM_WORDS);

    word_t                mem [`CPU_IMEM_WORDS];
    logic [IDX_BITS-1:0]  ridx; // upper address bits dropped, wraps
    logic [IDX_BITS-1:0]  widx;

    assign ridx = addr_i[BYTE_BITS +: IDX_BITS];
    assign widx = waddr_i[BYTE_BITS +: IDX_BITS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[widx] <= wdata_i;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[ridx];
    end

endmodule

//--- verilog/cpu_id.sv
`timescale 1ns/1ps

// instruction decode
// classifies, extracts fields, resolves jal straight back to fetch
module cpu_id (
    input  wire logic            clk_i,
    input  wire logic            reset_i,
    input  wire logic            halt_i,
    input  wire logic            ex_ready_i,  // advance enable

    input  wire common::if_out_t if_i,

    output logic                 jmp_valid_o, // combinational, same cycle as if_i
    output common::word_t        jmp_addr_o,

    output common::id_out_t      id_o,
    output logic                 id_valid_o
);

    import common::*;
    import rv_isa::*;

    // decoded form of NOP_IR in a bubble slot
    localparam id_out_t ID_NOP = '{
        pc:     NOP_PC,
        iclass: CLS_ALU_IMM,
        rd:     5'd0,
        rs1:    5'd0,
        rs2:    5'd0,
        imm:    '0,
        bubble: 1'b1
    };

    instr_u      ins;       // same word, r and m views
    opcode_t     opc;
    inst_class_t iclass;
    word_t       imm;
    word_t       j_off;     // kept apart so the target adder skips the imm mux
    logic        is_bubble;
    logic        is_jal;
    id_out_t     id_d;

    assign ins       = if_i.ir;
    assign opc       = ins.r.opcode;
    assign is_bubble = (if_i.pc == NOP_PC);

    // class and immediate format both follow the major opcode
    always_comb begin
        case (opc)
            OPC_OP:     begin iclass = CLS_ALU;     imm = '0;         end
            OPC_OP_IMM: begin iclass = CLS_ALU_IMM; imm = imm_i(ins); end
            OPC_LOAD:   begin iclass = CLS_LOAD;    imm = imm_i(ins); end
            OPC_STORE:  begin iclass = CLS_STORE;   imm = imm_s(ins); end
            OPC_BRANCH: begin iclass = CLS_BRANCH;  imm = imm_b(ins); end // not taken
            OPC_JAL:    begin iclass = CLS_JUMP;    imm = imm_j(ins); end
            OPC_JALR:   begin iclass = CLS_JUMP;    imm = imm_i(ins); end // left to ex
            OPC_LUI:    begin iclass = CLS_UPPER;   imm = imm_u(ins); end
            OPC_AUIPC:  begin iclass = CLS_UPPER;   imm = imm_u(ins); end
            default:    begin iclass = CLS_ILLEGAL; imm = '0;         end
        endcase
    end

    // jal resolved here
    // held back on halt or stall so the jal stays in if_o and retries
    assign is_jal      = (opc == OPC_JAL);
    assign j_off       = imm_j(ins);
    assign jmp_addr_o  = if_i.pc + j_off;
    assign jmp_valid_o = is_jal && ex_ready_i && !halt_i;

    always_comb begin
        id_d.pc     = if_i.pc;
        id_d.iclass = iclass;
        id_d.rd     = ins.r.rd;   // raw fields whatever the format
        id_d.rs1    = ins.r.rs1;
        id_d.rs2    = ins.r.rs2;
        id_d.imm    = imm;
        id_d.bubble = is_bubble;
    end

    // decode register, moves only when execute takes a word
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            id_o       <= ID_NOP;
            id_valid_o <= 1'b0;
        end else if (ex_ready_i) begin
            id_o       <= id_d;
            id_valid_o <= !is_bubble; // bubbles pass through as invalid
        end
    end

endmodule

//--- verilog/cpu_frontend.sv
`timescale 1ns/1ps

// pipeline front end: fetch, instruction memory, decode
module cpu_frontend (
    input  wire logic          clk_i,
    input  wire logic          reset_i,
    input  wire logic          halt_i,      // freezes pc, blocks redirects
    input  wire logic          ex_ready_i,  // back end takes a decoded word

    // program load port, one word per cycle
    input  wire logic          imem_we_i,
    input  wire common::word_t imem_waddr_i,
    input  wire common::word_t imem_wdata_i,

    output common::id_out_t    id_o,
    output logic               id_valid_o
);

    import common::*;

    word_t   imem_addr;  // next pc
    word_t   imem_data;  // word at fetch's current pc
    if_out_t if_out;     // fetch -> decode
    logic    jmp_valid;  // decode -> fetch, same cycle
    word_t   jmp_addr;

    cpu_if cpu_if_i (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .halt_i            (halt_i),
        .imem_addr_o       (imem_addr),
        .imem_data_i       (imem_data),
        .jmp_addr_async_i  (jmp_addr),
        .jmp_valid_async_i (jmp_valid),
        .ready_async_i     (ex_ready_i), // fetch and decode step together
        .if_o              (if_out)
    );

    imem imem_i (
        .clk_i   (clk_i),
        .addr_i  (imem_addr),
        .we_i    (imem_we_i),
        .waddr_i (imem_waddr_i),
        .wdata_i (imem_wdata_i),
        .rdata_o (imem_data)
    );

    cpu_id cpu_id_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .halt_i      (halt_i),
        .ex_ready_i  (ex_ready_i),
        .if_i        (if_out),
        .jmp_valid_o (jmp_valid),
        .jmp_addr_o  (jmp_addr),
        .id_o        (id_o),
        .id_valid_o  (id_valid_o)
    );

endmodule

//--- verification/frontend_model.svh
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// cycle model of pc, fetch register and decode register
word_t   m_mem [256];   // copy of the loaded program
word_t   m_pc;          // pc of word coming out of memory
word_t   m_if_pc;
word_t   m_if_ir;
id_out_t m_id;
logic    m_valid;

// immediate by format, bit positions straight from the isa manual
function automatic word_t ref_imm(word_t ir);
    case (ir[6:0])
        7'b0010011, 7'b0000011, 7'b1100111: return {{20{ir[31]}}, ir[31:20]};     // I
        7'b0100011: return {{20{ir[31]}}, ir[31:25], ir[11:7]};                   // S
        7'b1100011: return {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
        7'b0110111, 7'b0010111: return {ir[31:12], 12'h000};                      // U
        7'b1101111: return {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
        default: return 32'h0;                                                    // R, illegal
    endcase
endfunction

function automatic inst_class_t ref_class(word_t ir);
    case (ir[6:0])
        7'b0110011: return CLS_ALU;
        7'b0010011: return CLS_ALU_IMM;
        7'b0000011: return CLS_LOAD;
        7'b0100011: return CLS_STORE;
        7'b1100011: return CLS_BRANCH;
        7'b1101111, 7'b1100111: return CLS_JUMP;
        7'b0110111, 7'b0010111: return CLS_UPPER;
        default: return CLS_ILLEGAL;
    endcase
endfunction

function automatic id_out_t ref_decode(word_t pc, word_t ir);
    id_out_t d;
    d.pc     = pc;
    d.iclass = ref_class(ir);
    d.rd     = ir[11:7];
    d.rs1    = ir[19:15];
    d.rs2    = ir[24:20];
    d.imm    = ref_imm(ir);
    d.bubble = (pc == 32'hffff_ffff);
    return d;
endfunction

// one clock edge, inputs as the DUT saw them
task automatic model_step(input logic rst, input logic hlt, input logic rdy);
    logic  jmp;
    word_t jaddr;
    word_t pc_n;
    jmp   = (m_if_ir[6:0] == 7'b1101111) && rdy && !hlt;
    jaddr = m_if_pc + ref_imm(m_if_ir);
    if (rst) begin
        pc_n    = 32'h0;
        m_if_pc = 32'hffff_ffff;
        m_if_ir = 32'h0000_0013;    // addi x0,x0,0
        m_id    = ref_decode(32'hffff_ffff, 32'h0000_0013);
        m_valid = 1'b0;
    end else begin
        if (hlt) pc_n = m_pc;
        else if (jmp) pc_n = jaddr;
        else if (!rdy) pc_n = m_pc;
        else pc_n = m_pc + 32'd4;
        if (rdy) begin                  // decode sees the old fetch register
            m_id    = ref_decode(m_if_pc, m_if_ir);
            m_valid = (m_if_pc != 32'hffff_ffff);
        end
        if (jmp) begin
            m_if_pc = 32'hffff_ffff;
            m_if_ir = 32'h0000_0013;
        end else if (rdy && !hlt) begin // halted word stays put
            m_if_pc = m_pc;
            m_if_ir = m_mem[m_pc[9:2]];  // memory index wraps
        end
    end
    m_pc = pc_n;
endtask

`endif

//--- verification/tb_cpu_frontend.sv
`timescale 1ns/1ps

module tb_cpu_frontend;

    import common::*;
    import rv_isa::*;

    localparam int PROG_WORDS  = 256;
    localparam int STIM_CYCLES = 1500;
    localparam int CYCLE_LIMIT = 2000; // load + reset + stimulus, plus margin

    logic    clk_i = 1'b0;
    logic    reset_i, halt_i, ex_ready_i;
    logic    imem_we_i;
    word_t   imem_waddr_i, imem_wdata_i;
    id_out_t id_o;
    logic    id_valid_o;

    logic [15:0] lfsr_q = 16'd2520;
    word_t       prog [PROG_WORDS];
    int          mismatches = 0;
    int          failures = 0;
    int          cycles = 0;
    int          valid_seen = 0;
    logic        checking = 1'b0;
    word_t       last_pc = '1;     // newest valid pc seen at the output
    word_t       jal_target;
    logic        jal_open = 1'b0;  // that pc held a jal
    int          jal_hits = 0;     // redirects seen at the output

    `include "frontend_model.svh"

    cpu_frontend dut_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .halt_i       (halt_i),
        .ex_ready_i   (ex_ready_i),
        .imem_we_i    (imem_we_i),
        .imem_waddr_i (imem_waddr_i),
        .imem_wdata_i (imem_wdata_i),
        .id_o         (id_o),
        .id_valid_o   (id_valid_o)
    );

    always #20 clk_i = ~clk_i; // 40 ns period

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
        return r;
    endfunction

    function automatic word_t make_word();
        word_t body;
        word_t off;
        int    kind;
        body = rand_bits(25) << 7;  // fields above the opcode
        kind = int'(rand_bits(4));
        case (kind)
            0, 1:        return body | 32'h33;  // OP
            4:           return body | 32'h03;  // LOAD
            5:           return body | 32'h23;  // STORE
            6:           return body | 32'h63;  // BRANCH
            7:           return body | 32'h37;  // LUI
            8:           return body | 32'h17;  // AUIPC
            9:           return body | 32'h67;  // JALR
            10, 11: begin
                off = (rand_bits(4) + 32'd2) << 2;  // forward 8..68
                return {off[20], off[10:1], off[11], off[19:12], body[11:7], 7'b1101111};
            end
            12:          return body | 32'h7f;  // no such opcode
            default:     return body | 32'h13;  // OP_IMM
        endcase
    endfunction

    task automatic check_field(string name, word_t got, word_t exp);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_field("id_valid_o", word_t'(id_valid_o), word_t'(m_valid));
        check_field("id_o.pc", id_o.pc, m_id.pc);
        check_field("id_o.iclass", word_t'(id_o.iclass), word_t'(m_id.iclass));
        check_field("id_o.rd", word_t'(id_o.rd), word_t'(m_id.rd));
        check_field("id_o.rs1", word_t'(id_o.rs1), word_t'(m_id.rs1));
        check_field("id_o.rs2", word_t'(id_o.rs2), word_t'(m_id.rs2));
        check_field("id_o.imm", id_o.imm, m_id.imm);
        check_field("id_o.bubble", word_t'(id_o.bubble), word_t'(m_id.bubble));
    endtask

    // next new valid pc after a jal must be its target
    task automatic track_jal();
        word_t ir;
        if (id_valid_o && id_o.pc !== last_pc) begin
            if (jal_open) begin
                jal_hits++;
                assert (id_o.pc === jal_target) else begin
                    mismatches++;
                    $display("Mismatch at %0t ns: id_o.pc after jal got %h expected %h",
                             $time, id_o.pc, jal_target);
                end
            end
            ir         = prog[id_o.pc[9:2]];
            jal_open   = (ir[6:0] == 7'b1101111);
            jal_target = id_o.pc + ref_imm(ir);
            last_pc    = id_o.pc;
        end
    endtask

    // edge, model update, check, then new inputs a little later
    task automatic next_cycle();
        @(posedge clk_i);
        model_step(reset_i, halt_i, ex_ready_i);
        #2;
        if (checking) begin
            check_outputs();
            track_jal();
            if (id_valid_o) valid_seen++;
        end
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        reset_i      = 1'b1;
        halt_i       = 1'b0;
        ex_ready_i   = 1'b0;
        imem_we_i    = 1'b0;
        imem_waddr_i = '0;
        imem_wdata_i = '0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i]  = make_word();
            m_mem[i] = prog[i];
        end
        for (int i = 0; i < PROG_WORDS; i++) begin  // load under reset
            next_cycle();
            imem_we_i    = 1'b1;
            imem_waddr_i = word_t'(i * 4);
            imem_wdata_i = prog[i];
        end
        next_cycle();
        imem_we_i = 1'b0;
        repeat (8) next_cycle();  // reset proper
        reset_i  = 1'b0;
        checking = 1'b1;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            next_cycle();
            halt_i     = (rand_bits(5) < 32'd3);   // ~10 %
            ex_ready_i = (rand_bits(2) != 32'd0);  // 75 %
        end
        assert (valid_seen > 0) else begin
            failures++;
            $display("no valid instruction ever left decode");
        end
        assert (jal_hits > 0) else begin
            failures++;
            $display("no jal redirect ever reached the decode output");
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verilog
+incdir+verification
verilog/rv_isa.sv
verilog/common.sv
verilog/cpu_if.sv
verilog/imem.sv
verilog/cpu_id.sv
verilog/cpu_frontend.sv
verification/tb_cpu_frontend.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
TOP        ?= tb_cpu_frontend
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
